// ==== logic/mbtrain_pkg.sv ====
`default_nettype none

package mbtrain_pkg;

	localparam int NUM_STEPS   = 13;
	localparam int STEP_W      = 4;
	localparam int SPEED_W     = 3;
	localparam int LANE_HALVES = 2;
	localparam int RESOLVE_W   = 2;
	localparam int MUX_W       = 3;

	// values are the sideband substate codes
	typedef enum logic [STEP_W-1:0] {
		ST_VALVREF            = 4'd0,
		ST_DATAVREF           = 4'd1,
		ST_SPEED_IDLE         = 4'd2,
		ST_TX_SELF_CAL        = 4'd3,
		ST_RX_CLK_CAL         = 4'd4,
		ST_VAL_TRAIN_CENTER   = 4'd5,
		ST_VAL_TRAIN_VREF     = 4'd6,
		ST_DATA_TRAIN_CENTER1 = 4'd7,
		ST_DATA_TRAIN_VREF    = 4'd8,
		ST_RX_DESKEW          = 4'd9,
		ST_DATA_TRAIN_CENTER2 = 4'd10,
		ST_LINK_SPEED         = 4'd11,
		ST_REPAIR             = 4'd12
	} step_e;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_RUN,
		SEQ_DRAIN,
		SEQ_FINISH
	} seq_state_e;

	// pattern generator / detector select
	typedef enum logic [MUX_W-1:0] {
		MUX_VREF_CAL     = 3'd0,
		MUX_SELF_CAL     = 3'd1,
		MUX_LINK_SPEED   = 3'd2,
		MUX_REPAIR       = 3'd3,
		MUX_TRAIN_CENTER = 3'd4,
		MUX_RX_CAL       = 3'd5
	} mux_sel_e;

	// outcome of the retrain resolution
	typedef enum logic [RESOLVE_W-1:0] {
		RES_FULL     = 2'd0,
		RES_SELF_CAL = 2'd1,
		RES_REPAIR   = 2'd2,
		RES_DEGRADE  = 2'd3
	} resolve_e;

	function automatic mux_sel_e step_mux(input step_e s);
		case (s)
			ST_SPEED_IDLE, ST_TX_SELF_CAL:                     return MUX_SELF_CAL;
			ST_RX_CLK_CAL, ST_RX_DESKEW:                       return MUX_RX_CAL;
			ST_VAL_TRAIN_CENTER, ST_DATA_TRAIN_CENTER1,
			ST_DATA_TRAIN_CENTER2:                             return MUX_TRAIN_CENTER;
			ST_LINK_SPEED:                                     return MUX_LINK_SPEED;
			ST_REPAIR:                                         return MUX_REPAIR;
			default:                                           return MUX_VREF_CAL;
		endcase
	endfunction

	// high when the valid lane is under test rather than the mainband
	function automatic logic step_valtest(input step_e s);
		return (s == ST_VALVREF) || (s == ST_VAL_TRAIN_CENTER) || (s == ST_VAL_TRAIN_VREF);
	endfunction

endpackage

`default_nettype wire

// ==== logic/mbtrain_step_if.sv ====
`default_nettype none

interface mbtrain_step_if
	import mbtrain_pkg::*;
();

	// substate entered at this edge, step is valid with it
	logic  enter;
	step_e step;
	// current enable must drop
	logic  leave;
	// full training start and speed decrement
	logic  start;
	logic  degrade;
	// link speed and repair completion
	logic  ls_exit;
	logic  rp_exit;
	// end of training, retrain qualifies finish
	logic  finish;
	logic  retrain;
	logic  restart;

	modport source (
		output enter, step, leave, start, degrade, ls_exit, rp_exit, finish, retrain, restart
	);

	modport sink (
		input enter, step, leave, start, degrade, ls_exit, rp_exit, finish, retrain, restart
	);

endinterface

`default_nettype wire

// ==== logic/mbtrain_sequencer.sv ====
`default_nettype none

module mbtrain_sequencer
	import mbtrain_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_en,
	input  resolve_e             i_resolved,
	input  logic [NUM_STEPS-1:0] i_step_ack,
	input  logic                 i_retrain_req,
	input  logic                 i_error_req,
	input  logic                 i_degrade_req,
	mbtrain_step_if.source       ev
);

	seq_state_e state_q;
	seq_state_e state_d;
	step_e      step_q;
	step_e      step_d;
	logic       ack;

	// acknowledge of the substate in progress
	assign ack = i_step_ack[step_q];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= SEQ_IDLE;
			step_q  <= ST_VALVREF;
		end else begin
			state_q <= state_d;
			step_q  <= step_d;
		end
	end

	always_comb begin
		state_d    = state_q;
		step_d     = step_q;
		ev.enter   = 1'b0;
		ev.leave   = 1'b0;
		ev.start   = 1'b0;
		ev.degrade = 1'b0;
		ev.ls_exit = 1'b0;
		ev.rp_exit = 1'b0;
		ev.finish  = 1'b0;
		ev.retrain = 1'b0;
		ev.restart = 1'b0;
		case (state_q)
			SEQ_IDLE: begin
				if (i_en) begin
					state_d  = SEQ_RUN;
					ev.enter = 1'b1;
					// entry point follows the resolved retrain state
					case (i_resolved)
						RES_SELF_CAL: step_d = ST_TX_SELF_CAL;
						RES_REPAIR:   step_d = ST_REPAIR;
						RES_DEGRADE: begin
							step_d     = ST_SPEED_IDLE;
							ev.degrade = 1'b1;
						end
						default: begin
							step_d   = ST_VALVREF;
							ev.start = 1'b1;
						end
					endcase
				end
			end
			SEQ_RUN: begin
				if (ack) begin
					ev.leave = 1'b1;
					if (step_q == ST_LINK_SPEED) begin
						ev.ls_exit = 1'b1;
						if (i_retrain_req) begin
							state_d    = SEQ_FINISH;
							ev.finish  = 1'b1;
							ev.retrain = 1'b1;
						end else if (i_error_req && i_degrade_req) begin
							step_d     = ST_SPEED_IDLE;
							ev.enter   = 1'b1;
							ev.degrade = 1'b1;
						end else if (i_error_req) begin
							step_d   = ST_REPAIR;
							ev.enter = 1'b1;
						end else begin
							state_d   = SEQ_FINISH;
							ev.finish = 1'b1;
						end
					end else if (step_q == ST_REPAIR) begin
						// lanes changed, so calibrate again
						ev.rp_exit = 1'b1;
						step_d     = ST_TX_SELF_CAL;
						ev.enter   = 1'b1;
					end else begin
						state_d = SEQ_DRAIN;
					end
				end
			end
			SEQ_DRAIN: begin
				// training chain is in code order up to link speed
				if (!ack) begin
					state_d  = SEQ_RUN;
					step_d   = step_e'(step_q + STEP_W'(1));
					ev.enter = 1'b1;
				end
			end
			default: begin
				if (!i_en) begin
					state_d    = SEQ_IDLE;
					ev.restart = 1'b1;
				end
			end
		endcase
		ev.step = step_d;
	end

	a_step_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		(state_q inside {SEQ_RUN, SEQ_DRAIN}) |-> (int'(step_q) < NUM_STEPS));

endmodule

`default_nettype wire

// ==== logic/mbtrain_step_driver.sv ====
`default_nettype none

module mbtrain_step_driver
	import mbtrain_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	mbtrain_step_if.sink         ev,
	output logic [NUM_STEPS-1:0] o_step_en,
	output step_e                o_sideband_substate,
	output mux_sel_e             o_mux_sel,
	output logic                 o_valtest,
	output logic                 o_phyretrain_en,
	output logic                 o_mbtrain_ack
);

	logic finish_q;
	logic restart_q;

	// enter overrides leave, link speed and repair hand over in one edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_step_en <= '0;
		end else if (ev.enter) begin
			o_step_en <= NUM_STEPS'(1) << ev.step;
		end else if (ev.leave) begin
			o_step_en <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (ev.enter) begin
			o_sideband_substate <= ev.step;
			o_mux_sel           <= step_mux(ev.step);
			o_valtest           <= step_valtest(ev.step);
		end else if (ev.finish) begin
			o_sideband_substate <= ST_VALVREF;
		end
	end

	// done follows finish by one edge, cleared one edge into idle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			finish_q        <= 1'b0;
			restart_q       <= 1'b0;
			o_mbtrain_ack   <= 1'b0;
			o_phyretrain_en <= 1'b0;
		end else begin
			finish_q  <= ev.finish;
			restart_q <= ev.restart;
			if (restart_q) begin
				o_mbtrain_ack   <= 1'b0;
				o_phyretrain_en <= 1'b0;
			end else begin
				if (finish_q) begin
					o_mbtrain_ack <= 1'b1;
				end
				if (ev.finish) begin
					o_phyretrain_en <= ev.retrain;
				end
			end
		end
	end

	a_en_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(o_step_en));

endmodule

`default_nettype wire

// ==== logic/mbtrain_link_tracker.sv ====
`default_nettype none

module mbtrain_link_tracker
	import mbtrain_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	mbtrain_step_if.sink           ev,
	input  logic [SPEED_W-1:0]     i_highest_speed,
	input  logic [LANE_HALVES-1:0] i_init_tx_lanes,
	input  logic [LANE_HALVES-1:0] i_init_rx_lanes,
	input  logic [LANE_HALVES-1:0] i_ls_tx_lanes,
	input  logic [LANE_HALVES-1:0] i_rp_rx_lanes,
	output logic [SPEED_W-1:0]     o_speed,
	output logic [LANE_HALVES-1:0] o_tx_lanes,
	output logic [LANE_HALVES-1:0] o_rx_lanes
);

	// operating speed, one step down per degrade
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_speed <= '0;
		end else if (ev.start) begin
			o_speed <= i_highest_speed;
		end else if (ev.degrade) begin
			o_speed <= o_speed - SPEED_W'(1);
		end
	end

	// tx halves are final after link speed, an all-zero result keeps the old mask
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_tx_lanes <= '0;
		end else if (ev.start) begin
			o_tx_lanes <= i_init_tx_lanes;
		end else if (ev.ls_exit && (|i_ls_tx_lanes)) begin
			o_tx_lanes <= i_ls_tx_lanes;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_rx_lanes <= '0;
		end else if (ev.start) begin
			o_rx_lanes <= i_init_rx_lanes;
		end else if (ev.rp_exit) begin
			o_rx_lanes <= i_rp_rx_lanes;
		end
	end

	a_no_degrade_at_zero: assert property (@(posedge clk) disable iff (!rst_n)
		ev.degrade |-> (o_speed != '0));

endmodule

`default_nettype wire

// ==== logic/mbtrain_top.sv ====
`default_nettype none

module mbtrain_top
	import mbtrain_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_en,
	input  logic [RESOLVE_W-1:0]   i_phyretrain_resolved_state,
	input  logic [NUM_STEPS-1:0]   i_step_ack,
	input  logic                   i_retrain_req,
	input  logic                   i_error_req,
	input  logic                   i_degrade_req,
	input  logic [SPEED_W-1:0]     i_highest_speed,
	input  logic [LANE_HALVES-1:0] i_init_tx_lanes,
	input  logic [LANE_HALVES-1:0] i_init_rx_lanes,
	input  logic [LANE_HALVES-1:0] i_ls_tx_lanes,
	input  logic [LANE_HALVES-1:0] i_rp_rx_lanes,
	output logic [NUM_STEPS-1:0]   o_step_en,
	output logic [STEP_W-1:0]      o_sideband_substate,
	output logic [MUX_W-1:0]       o_mux_sel,
	output logic                   o_valtest,
	output logic                   o_phyretrain_en,
	output logic                   o_mbtrain_ack,
	output logic [SPEED_W-1:0]     o_speed,
	output logic [LANE_HALVES-1:0] o_tx_lanes,
	output logic [LANE_HALVES-1:0] o_rx_lanes
);

	step_e    sideband;
	mux_sel_e mux_sel;

	mbtrain_step_if step_if ();

	mbtrain_sequencer sequencer_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_en          (i_en),
		.i_resolved    (resolve_e'(i_phyretrain_resolved_state)),
		.i_step_ack    (i_step_ack),
		.i_retrain_req (i_retrain_req),
		.i_error_req   (i_error_req),
		.i_degrade_req (i_degrade_req),
		.ev            (step_if.source)
	);

	mbtrain_step_driver step_driver_i (
		.clk                 (clk),
		.rst_n               (rst_n),
		.ev                  (step_if.sink),
		.o_step_en           (o_step_en),
		.o_sideband_substate (sideband),
		.o_mux_sel           (mux_sel),
		.o_valtest           (o_valtest),
		.o_phyretrain_en     (o_phyretrain_en),
		.o_mbtrain_ack       (o_mbtrain_ack)
	);

	// sideband and pattern select leave as plain codes
	assign o_sideband_substate = sideband;
	assign o_mux_sel           = mux_sel;

	mbtrain_link_tracker link_tracker_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.ev              (step_if.sink),
		.i_highest_speed (i_highest_speed),
		.i_init_tx_lanes (i_init_tx_lanes),
		.i_init_rx_lanes (i_init_rx_lanes),
		.i_ls_tx_lanes   (i_ls_tx_lanes),
		.i_rp_rx_lanes   (i_rp_rx_lanes),
		.o_speed         (o_speed),
		.o_tx_lanes      (o_tx_lanes),
		.o_rx_lanes      (o_rx_lanes)
	);

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
	output logic o_clk,
	output logic o_rst_n
);

	localparam int HALF_PERIOD  = 50;
	localparam int RESET_CYCLES = 8;

	initial begin
		o_clk = 1'b0;
		forever #HALF_PERIOD o_clk = ~o_clk;
	end

	// reset released on a falling edge, away from the sampling edge
	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb/tb_mbtrain.sv ====
`default_nettype none

module tb_mbtrain
	import mbtrain_pkg::*;
();

	localparam int MAX_VECS    = 16;
	localparam int FIELDS      = 12;
	localparam int LIST_DIGITS = 24;
	localparam int CYCLES_PER_STEP = 20;

	logic                   clk;
	logic                   rst_n;
	logic                   i_en;
	logic [RESOLVE_W-1:0]   i_phyretrain_resolved_state;
	logic [NUM_STEPS-1:0]   i_step_ack;
	logic                   i_retrain_req;
	logic                   i_error_req;
	logic                   i_degrade_req;
	logic [SPEED_W-1:0]     i_highest_speed;
	logic [LANE_HALVES-1:0] i_init_tx_lanes;
	logic [LANE_HALVES-1:0] i_init_rx_lanes;
	logic [LANE_HALVES-1:0] i_ls_tx_lanes;
	logic [LANE_HALVES-1:0] i_rp_rx_lanes;
	logic [NUM_STEPS-1:0]   o_step_en;
	logic [STEP_W-1:0]      o_sideband_substate;
	logic [MUX_W-1:0]       o_mux_sel;
	logic                   o_valtest;
	logic                   o_phyretrain_en;
	logic                   o_mbtrain_ack;
	logic [SPEED_W-1:0]     o_speed;
	logic [LANE_HALVES-1:0] o_tx_lanes;
	logic [LANE_HALVES-1:0] o_rx_lanes;

	// twelve words per vector, see the header of the vector file
	logic [95:0] vec_mem [0:MAX_VECS*FIELDS-1];
	int          num_vecs;
	int          error_count;
	int          check_count;
	int          cycle_count;
	int          cycle_limit;
	logic [15:0] lfsr;

	tb_clock_gen clock_gen_i (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	mbtrain_top dut_i (
		.clk                         (clk),
		.rst_n                       (rst_n),
		.i_en                        (i_en),
		.i_phyretrain_resolved_state (i_phyretrain_resolved_state),
		.i_step_ack                  (i_step_ack),
		.i_retrain_req               (i_retrain_req),
		.i_error_req                 (i_error_req),
		.i_degrade_req               (i_degrade_req),
		.i_highest_speed             (i_highest_speed),
		.i_init_tx_lanes             (i_init_tx_lanes),
		.i_init_rx_lanes             (i_init_rx_lanes),
		.i_ls_tx_lanes               (i_ls_tx_lanes),
		.i_rp_rx_lanes               (i_rp_rx_lanes),
		.o_step_en                   (o_step_en),
		.o_sideband_substate         (o_sideband_substate),
		.o_mux_sel                   (o_mux_sel),
		.o_valtest                   (o_valtest),
		.o_phyretrain_en             (o_phyretrain_en),
		.o_mbtrain_ack               (o_mbtrain_ack),
		.o_speed                     (o_speed),
		.o_tx_lanes                  (o_tx_lanes),
		.o_rx_lanes                  (o_rx_lanes)
	);

	// galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	task automatic draw_delay(output int cycles);
		int bits;
		bits = 0;
		for (int i = 0; i < 3; i++) begin
			bits = (bits << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
		cycles = bits + 1;
	endtask

	// vref substates share the vref calibration pattern
	function automatic logic [MUX_W-1:0] expected_mux(input int code);
		case (code)
			0, 1, 6, 8: return 3'd0;
			2, 3:       return 3'd1;
			11:         return 3'd2;
			12:         return 3'd3;
			5, 7, 10:   return 3'd4;
			4, 9:       return 3'd5;
			default:    return 3'd7;
		endcase
	endfunction

	function automatic logic expected_valtest(input int code);
		return (code == 0) || (code == 5) || (code == 6);
	endfunction

	// substate list ends at the first f digit
	function automatic int count_steps(input logic [95:0] list);
		int n;
		n = 0;
		while (n < LIST_DIGITS && list[95-4*n -: 4] != 4'hf) begin
			n++;
		end
		return n;
	endfunction

	task automatic run_vector(input int v);
		int                   base;
		logic [95:0]          list;
		int                   num_steps;
		int                   outcome;
		int                   ls_visits;
		int                   code;
		int                   exp_code;
		int                   delay;
		logic [NUM_STEPS-1:0] en;
		base      = v * FIELDS;
		list      = vec_mem[base+7];
		num_steps = count_steps(list);
		outcome   = int'(vec_mem[base+4][1:0]);
		ls_visits = 0;
		@(negedge clk);
		i_phyretrain_resolved_state = vec_mem[base][RESOLVE_W-1:0];
		i_highest_speed             = vec_mem[base+1][SPEED_W-1:0];
		i_init_tx_lanes             = vec_mem[base+2][LANE_HALVES-1:0];
		i_init_rx_lanes             = vec_mem[base+3][LANE_HALVES-1:0];
		i_ls_tx_lanes               = vec_mem[base+5][LANE_HALVES-1:0];
		i_rp_rx_lanes               = vec_mem[base+6][LANE_HALVES-1:0];
		i_en                        = 1'b1;
		for (int s = 0; s < num_steps; s++) begin
			while (o_step_en == '0) begin
				@(negedge clk);
			end
			en       = o_step_en;
			code     = int'(o_sideband_substate);
			exp_code = int'(list[95-4*s -: 4]);
			check_count++;
			if (code != exp_code) begin
				error_count++;
				$display("FAILED at time %0t: vector %0d step %0d entered substate %0d, expected %0d",
					$time, v, s, code, exp_code);
			end
			if (en != (NUM_STEPS'(1) << code)) begin
				error_count++;
				$display("FAILED at time %0t: vector %0d enable %b does not match substate %0d",
					$time, v, en, code);
			end
			if (o_mux_sel != expected_mux(code)) begin
				error_count++;
				$display("FAILED at time %0t: vector %0d substate %0d mux select %0d, expected %0d",
					$time, v, code, o_mux_sel, expected_mux(code));
			end
			if (o_valtest != expected_valtest(code)) begin
				error_count++;
				$display("FAILED at time %0t: vector %0d substate %0d test select %0b, expected %0b",
					$time, v, code, o_valtest, expected_valtest(code));
			end
			draw_delay(delay);
			repeat (delay) @(negedge clk);
			// the first link speed visit takes the vector outcome, later ones pass
			if (code == 11) begin
				ls_visits++;
				if (ls_visits == 1) begin
					i_retrain_req = (outcome == 1);
					i_error_req   = (outcome == 2) || (outcome == 3);
					i_degrade_req = (outcome == 2);
				end
			end
			i_step_ack = en;
			while ((o_step_en & en) != '0) begin
				@(negedge clk);
			end
			i_step_ack    = '0;
			i_retrain_req = 1'b0;
			i_error_req   = 1'b0;
			i_degrade_req = 1'b0;
		end
		while (!o_mbtrain_ack) begin
			@(negedge clk);
		end
		check_count++;
		if (o_step_en != '0) begin
			error_count++;
			$display("FAILED at time %0t: vector %0d enable %b still high at done",
				$time, v, o_step_en);
		end
		if (o_sideband_substate != '0) begin
			error_count++;
			$display("FAILED at time %0t: vector %0d sideband code %0d at done, expected 0",
				$time, v, o_sideband_substate);
		end
		if (o_phyretrain_en != vec_mem[base+11][0]) begin
			error_count++;
			$display("FAILED at time %0t: vector %0d retrain %0b, expected %0b",
				$time, v, o_phyretrain_en, vec_mem[base+11][0]);
		end
		if (o_speed != vec_mem[base+8][SPEED_W-1:0]) begin
			error_count++;
			$display("FAILED at time %0t: vector %0d speed %0d, expected %0d",
				$time, v, o_speed, vec_mem[base+8][SPEED_W-1:0]);
		end
		if (o_tx_lanes != vec_mem[base+9][LANE_HALVES-1:0]) begin
			error_count++;
			$display("FAILED at time %0t: vector %0d tx lanes %b, expected %b",
				$time, v, o_tx_lanes, vec_mem[base+9][LANE_HALVES-1:0]);
		end
		if (o_rx_lanes != vec_mem[base+10][LANE_HALVES-1:0]) begin
			error_count++;
			$display("FAILED at time %0t: vector %0d rx lanes %b, expected %b",
				$time, v, o_rx_lanes, vec_mem[base+10][LANE_HALVES-1:0]);
		end
		// done and retrain clear within two edges of the enable dropping
		i_en = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		if (o_mbtrain_ack || o_phyretrain_en) begin
			error_count++;
			$display("FAILED at time %0t: vector %0d done %0b retrain %0b after enable low",
				$time, v, o_mbtrain_ack, o_phyretrain_en);
		end
	endtask

	always @(negedge clk) begin
		if (rst_n && ($countones(o_step_en) > 1)) begin
			error_count++;
			$display("FAILED at time %0t: more than one enable high, %b", $time, o_step_en);
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, the DUT stopped responding", cycle_count);
			$display("checks: %0d, errors: %0d", check_count, error_count + 1);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		int v;
		i_en                        = 1'b0;
		i_phyretrain_resolved_state = '0;
		i_step_ack                  = '0;
		i_retrain_req               = 1'b0;
		i_error_req                 = 1'b0;
		i_degrade_req               = 1'b0;
		i_highest_speed             = '0;
		i_init_tx_lanes             = '0;
		i_init_rx_lanes             = '0;
		i_ls_tx_lanes               = '0;
		i_rp_rx_lanes               = '0;
		error_count                 = 0;
		check_count                 = 0;
		cycle_count                 = 0;
		lfsr                        = 16'd36437;
		for (int i = 0; i < MAX_VECS * FIELDS; i++) begin
			vec_mem[i] = '1;
		end
		$readmemh("tb/mbtrain_vectors.txt", vec_mem);
		num_vecs = 0;
		while (num_vecs < MAX_VECS && vec_mem[num_vecs*FIELDS] != '1) begin
			num_vecs++;
		end
		if (num_vecs == 0) begin
			error_count++;
			$display("no vectors could be read from tb/mbtrain_vectors.txt");
		end
		cycle_limit = 200;
		for (v = 0; v < num_vecs; v++) begin
			cycle_limit += count_steps(vec_mem[v*FIELDS+7]) * CYCLES_PER_STEP;
		end

		wait (rst_n === 1'b1);
		@(negedge clk);
		check_count++;
		if (o_step_en != '0 || o_mbtrain_ack || o_phyretrain_en ||
			o_speed != '0 || o_tx_lanes != '0 || o_rx_lanes != '0) begin
			error_count++;
			$display("FAILED at time %0t: outputs not zero after reset", $time);
		end

		for (v = 0; v < num_vecs; v++) begin
			run_vector(v);
		end

		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/mbtrain_vectors.txt ====
// resolve hi_speed init_tx init_rx outcome(0 pass 1 retrain 2 degrade 3 repair) ls_tx rp_rx
// substates (one hex digit each, f pads to 24) exp_speed exp_tx exp_rx exp_retrain
0 5 3 3 0 0 0 0123456789abffffffffffff 5 3 3 0
0 4 3 3 2 1 0 0123456789ab23456789abff 3 1 3 0
0 6 3 3 3 0 2 0123456789abc3456789abff 6 3 2 0
1 7 0 0 0 2 0 3456789abfffffffffffffff 6 2 2 0
2 0 0 0 0 0 1 c3456789abffffffffffffff 6 2 1 0
3 0 0 0 0 3 0 23456789abffffffffffffff 5 3 1 0
0 2 1 2 1 0 0 0123456789abffffffffffff 2 1 2 1
0 7 2 1 1 3 0 0123456789abffffffffffff 7 3 1 1

// ==== files.f ====
logic/mbtrain_pkg.sv
logic/mbtrain_step_if.sv
logic/mbtrain_sequencer.sv
logic/mbtrain_step_driver.sv
logic/mbtrain_link_tracker.sv
logic/mbtrain_top.sv
tb/tb_clock_gen.sv
tb/tb_mbtrain.sv

// ==== Makefile ====
# Verilator simulation of the mainband training sequencer

VERILATOR ?= verilator
TOP       ?= tb_mbtrain
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
